/* common/dec_cfg.svh */
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// ************************************************************
// architectural register file sizing
// ************************************************************

`define DEC_NUM_GPR 32         // x0..x31
`define DEC_XLEN    32         // register width
`define DEC_NUM_WP  3          // i0 wb, i1 wb, nonblock load
`define DEC_NUM_RP  4          // i0 rs1/rs2, i1 rs1/rs2

// ************************************************************
// retirement trace
// ************************************************************

`define DEC_TRACE_W 3          // trace lanes: i0, i1, interrupt

`endif

/* common/dec_pkg.sv */
`include "dec_cfg.svh"

package dec_pkg;

   typedef logic [$clog2(`DEC_NUM_GPR)-1:0] gpr_addr_t;   // register index
   typedef logic [`DEC_XLEN-1:0]            gpr_data_t;   // register value
   typedef logic [`DEC_NUM_WP-1:0]          wp_sel_t;     // one-hot of write ports

   // write port slots, nonblock load has top priority
   localparam int WP_I0     = 0;
   localparam int WP_I1     = 1;
   localparam int WP_NBLOAD = 2;

   // retirement trace packet, lane 2 is interrupt, lane 1 is i1, lane 0 is i0
   typedef struct packed {
      logic [`DEC_TRACE_W-1:0]           valid;       // per-lane retire
      logic [`DEC_TRACE_W-1:0]           exception;   // per-lane exception
      logic [`DEC_TRACE_W-1:0]           interrupt;   // only top lane used
      logic [4:0]                        ecause;      // shared across lanes
      gpr_data_t                         tval;        // shared across lanes
      logic [`DEC_TRACE_W*`DEC_XLEN-1:0] insn;        // {0, i1, i0}
      logic [`DEC_TRACE_W*`DEC_XLEN-1:0] address;     // {0, i1 pc, i0 pc}
   } trace_pkt_t;

endpackage

/* common/gpr_wr_if.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

// three register write ports, plain levels sampled at clk
interface gpr_wr_if;

   logic [`DEC_NUM_WP-1:0]                   wen;     // per-port write enable
   dec_pkg::gpr_addr_t [`DEC_NUM_WP-1:0]     waddr;   // per-port target
   dec_pkg::gpr_data_t [`DEC_NUM_WP-1:0]     wdata;   // per-port value

   // top level drives the ports
   modport src (
      output wen,
      output waddr,
      output wdata
   );

   // write selector inside the register file
   modport dst (
      input  wen,
      input  waddr,
      input  wdata
   );

endinterface

/* arf/dec_gpr_wsel.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_gpr_wsel (
   gpr_wr_if.dst                 wr,                    // three write ports
   output logic [`DEC_NUM_GPR-1:0] we,                  // per-entry strobe
   output dec_pkg::gpr_data_t    wd [`DEC_NUM_GPR]      // per-entry winning data
);

   import dec_pkg::*;

   // x0 is hardwired, writes to it are dropped
   assign we[0] = 1'b0;
   assign wd[0] = '0;

   // ************************************************************
   // per-register port match and priority pick
   // ************************************************************

   for (genvar g = 1; g < `DEC_NUM_GPR; g++) begin : g_sel
      wp_sel_t hit;                                     // ports aiming at this reg

      for (genvar p = 0; p < `DEC_NUM_WP; p++) begin : g_port
         assign hit[p] = wr.wen[p] & (wr.waddr[p] == gpr_addr_t'(g));
      end

      assign we[g] = |hit;                              // any port writes

      // nbload beats i1, i1 beats i0
      assign wd[g] = hit[WP_NBLOAD] ? wr.wdata[WP_NBLOAD] :
                     hit[WP_I1]     ? wr.wdata[WP_I1]     :
                                      wr.wdata[WP_I0];
   end

endmodule

/* arf/dec_gpr_entry.sv */
`timescale 1ns/1ps

// one architectural register
module dec_gpr_entry (
   input  logic               clk,
   input  logic               rst,
   input  logic               we,      // write strobe from selector
   input  dec_pkg::gpr_data_t wd,      // selected write data
   output dec_pkg::gpr_data_t q        // current value
);

   // a per-entry clock gate would hang off we here
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;                      // regs come up as zero
      end else if (we) begin
         q <= wd;                      // new value visible next cycle
      end
   end

endmodule

/* arf/dec_gpr_rmux.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_gpr_rmux (
   input  dec_pkg::gpr_data_t      regs  [`DEC_NUM_GPR],  // all register values
   input  dec_pkg::gpr_addr_t      raddr [`DEC_NUM_RP],   // per-port read index
   input  logic [`DEC_NUM_RP-1:0]  rden,                  // per-port read enable
   output dec_pkg::gpr_data_t      rd    [`DEC_NUM_RP]    // per-port read data
);

   // ************************************************************
   // independent read selections, same-cycle combinational
   // ************************************************************

   for (genvar r = 0; r < `DEC_NUM_RP; r++) begin : g_rd
      logic live;                                        // enabled and not x0

      assign live = rden[r] & (|raddr[r]);

      // old value on same-cycle write, entries update at the edge
      assign rd[r] = live ? regs[raddr[r]] : '0;
   end

endmodule

/* arf/dec_gpr_ctl.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

// architectural register file, 3 write / 4 read
module dec_gpr_ctl (
   input  logic                    clk,
   input  logic                    rst,
   gpr_wr_if.dst                   wr,                     // write ports
   input  dec_pkg::gpr_addr_t      raddr [`DEC_NUM_RP],    // read indices
   input  logic [`DEC_NUM_RP-1:0]  rden,                   // read enables
   output dec_pkg::gpr_data_t      rd    [`DEC_NUM_RP]     // read data
);

   import dec_pkg::*;

   logic [`DEC_NUM_GPR-1:0] we;                  // per-entry strobe
   gpr_data_t               wd   [`DEC_NUM_GPR]; // per-entry write data
   gpr_data_t               regs [`DEC_NUM_GPR]; // flattened register values

   dec_gpr_wsel wsel (
      .wr (wr),
      .we (we),
      .wd (wd)
   );

   assign regs[0] = '0;                          // x0 is not stored

   for (genvar g = 1; g < `DEC_NUM_GPR; g++) begin : g_ent
      dec_gpr_entry ent (
         .clk (clk),
         .rst (rst),
         .we  (we[g]),
         .wd  (wd[g]),
         .q   (regs[g])
      );
   end

   dec_gpr_rmux rmux (
      .regs  (regs),
      .raddr (raddr),
      .rden  (rden),
      .rd    (rd)
   );

endmodule

/* source/dec_trace.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec_trace (
   input  logic               clk,
   input  logic               rst,
   input  logic               i0_valid_wb,       // i0 retires
   input  logic               i1_valid_wb,       // i1 retires
   input  logic               i0_exc_valid_wb,   // i0 takes exception
   input  logic               i1_exc_valid_wb,   // i1 takes exception
   input  logic               int_valid_wb,      // interrupt taken
   input  dec_pkg::gpr_data_t i0_inst_wb,
   input  dec_pkg::gpr_data_t i1_inst_wb,
   input  logic [31:1]        i0_pc_wb,          // halfword aligned
   input  logic [31:1]        i1_pc_wb,
   input  logic [4:0]         exc_cause_wb,
   input  dec_pkg::gpr_data_t mtval_wb,
   output dec_pkg::trace_pkt_t trace_pkt
);

   import dec_pkg::*;

   logic        i0_valid_wb1, i1_valid_wb1;
   logic        i0_exc_valid_wb1, i1_exc_valid_wb1;
   logic        int_valid_wb1;
   gpr_data_t   i0_inst_wb1, i1_inst_wb1;
   logic [31:1] i0_pc_wb1, i1_pc_wb1;
   logic [4:0]  exc_cause_wb1;
   gpr_data_t   mtval_wb1;

   // ************************************************************
   // wb1 stage
   // ************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         i0_valid_wb1     <= 1'b0;
         i1_valid_wb1     <= 1'b0;
         i0_exc_valid_wb1 <= 1'b0;
         i1_exc_valid_wb1 <= 1'b0;
         int_valid_wb1    <= 1'b0;
      end else begin
         i0_valid_wb1     <= i0_valid_wb;
         i1_valid_wb1     <= i1_valid_wb;
         i0_exc_valid_wb1 <= i0_exc_valid_wb;
         i1_exc_valid_wb1 <= i1_exc_valid_wb;
         int_valid_wb1    <= int_valid_wb;
      end
   end

   always_ff @(posedge clk) begin
      i0_inst_wb1   <= i0_inst_wb;
      i1_inst_wb1   <= i1_inst_wb;
      i0_pc_wb1     <= i0_pc_wb;
      i1_pc_wb1     <= i1_pc_wb;
      exc_cause_wb1 <= exc_cause_wb;
      mtval_wb1     <= mtval_wb;
   end

   // ************************************************************
   // packet assembly
   // ************************************************************

   assign trace_pkt.valid     = {int_valid_wb1,                          // int lane
                                 i1_valid_wb1 | i1_exc_valid_wb1,        // i1 lane
                                 i0_valid_wb1 | i0_exc_valid_wb1};       // i0 lane
   assign trace_pkt.exception = {int_valid_wb1, i1_exc_valid_wb1, i0_exc_valid_wb1};
   assign trace_pkt.interrupt = {int_valid_wb1, 2'b00};                  // top lane only
   assign trace_pkt.ecause    = exc_cause_wb1;                           // shared
   assign trace_pkt.tval      = mtval_wb1;                               // shared
   assign trace_pkt.insn      = {{`DEC_XLEN{1'b0}}, i1_inst_wb1, i0_inst_wb1};
   assign trace_pkt.address   = {{`DEC_XLEN{1'b0}}, i1_pc_wb1, 1'b0, i0_pc_wb1, 1'b0};

endmodule

/* source/dec.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dec (
   input  logic                clk,
   input  logic                rst,

   input  dec_pkg::gpr_addr_t  i0_waddr_wb,       // slot 0 writeback
   input  logic                i0_wen_wb,
   input  dec_pkg::gpr_data_t  i0_wdata_wb,
   input  dec_pkg::gpr_addr_t  i1_waddr_wb,       // slot 1 writeback
   input  logic                i1_wen_wb,
   input  dec_pkg::gpr_data_t  i1_wdata_wb,
   input  dec_pkg::gpr_addr_t  nbload_waddr,      // nonblock load return
   input  logic                nbload_wen,
   input  dec_pkg::gpr_data_t  nbload_wdata,

   input  dec_pkg::gpr_addr_t  i0_rs1,
   input  dec_pkg::gpr_addr_t  i0_rs2,
   input  dec_pkg::gpr_addr_t  i1_rs1,
   input  dec_pkg::gpr_addr_t  i1_rs2,
   input  logic                i0_rs1_en,
   input  logic                i0_rs2_en,
   input  logic                i1_rs1_en,
   input  logic                i1_rs2_en,
   output dec_pkg::gpr_data_t  gpr_i0_rs1_d,      // gpr read data
   output dec_pkg::gpr_data_t  gpr_i0_rs2_d,
   output dec_pkg::gpr_data_t  gpr_i1_rs1_d,
   output dec_pkg::gpr_data_t  gpr_i1_rs2_d,

   output dec_pkg::gpr_data_t  dbg_rddata,        // debug command read data

   input  logic                i0_valid_wb,       // retire info at wb
   input  logic                i1_valid_wb,
   input  logic                i0_exc_valid_wb,
   input  logic                i1_exc_valid_wb,
   input  logic                int_valid_wb,
   input  dec_pkg::gpr_data_t  i0_inst_wb,
   input  dec_pkg::gpr_data_t  i1_inst_wb,
   input  logic [31:1]         i0_pc_wb,
   input  logic [31:1]         i1_pc_wb,
   input  logic [4:0]          exc_cause_wb,
   input  dec_pkg::gpr_data_t  mtval_wb,
   output dec_pkg::trace_pkt_t trace_rv_trace_pkt // retirement trace
);

   import dec_pkg::*;

   gpr_addr_t              raddr [`DEC_NUM_RP];   // 0..3: i0 rs1, i0 rs2, i1 rs1, i1 rs2
   logic [`DEC_NUM_RP-1:0] rden;
   gpr_data_t              rd    [`DEC_NUM_RP];

   // ************************************************************
   // register file
   // ************************************************************

   gpr_wr_if wr_bus ();

   assign wr_bus.wen[WP_I0]       = i0_wen_wb;
   assign wr_bus.waddr[WP_I0]     = i0_waddr_wb;
   assign wr_bus.wdata[WP_I0]     = i0_wdata_wb;
   assign wr_bus.wen[WP_I1]       = i1_wen_wb;
   assign wr_bus.waddr[WP_I1]     = i1_waddr_wb;
   assign wr_bus.wdata[WP_I1]     = i1_wdata_wb;
   assign wr_bus.wen[WP_NBLOAD]   = nbload_wen;
   assign wr_bus.waddr[WP_NBLOAD] = nbload_waddr;
   assign wr_bus.wdata[WP_NBLOAD] = nbload_wdata;

   assign raddr[0] = i0_rs1;
   assign raddr[1] = i0_rs2;
   assign raddr[2] = i1_rs1;
   assign raddr[3] = i1_rs2;
   assign rden     = {i1_rs2_en, i1_rs1_en, i0_rs2_en, i0_rs1_en};

   dec_gpr_ctl arf (
      .clk   (clk),
      .rst   (rst),
      .wr    (wr_bus.dst),
      .raddr (raddr),
      .rden  (rden),
      .rd    (rd)
   );

   assign gpr_i0_rs1_d = rd[0];
   assign gpr_i0_rs2_d = rd[1];
   assign gpr_i1_rs1_d = rd[2];
   assign gpr_i1_rs2_d = rd[3];

   assign dbg_rddata = i0_wdata_wb;        // debug reads ride on slot 0 wb data

   // ************************************************************
   // trace
   // ************************************************************

   dec_trace trc (
      .clk             (clk),
      .rst             (rst),
      .i0_valid_wb     (i0_valid_wb),
      .i1_valid_wb     (i1_valid_wb),
      .i0_exc_valid_wb (i0_exc_valid_wb),
      .i1_exc_valid_wb (i1_exc_valid_wb),
      .int_valid_wb    (int_valid_wb),
      .i0_inst_wb      (i0_inst_wb),
      .i1_inst_wb      (i1_inst_wb),
      .i0_pc_wb        (i0_pc_wb),
      .i1_pc_wb        (i1_pc_wb),
      .exc_cause_wb    (exc_cause_wb),
      .mtval_wb        (mtval_wb),
      .trace_pkt       (trace_rv_trace_pkt)
   );

endmodule

/* dv/dec_sva.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

// bound into dec_gpr_ctl and dec_trace, unused side tied to zero
module dec_sva (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`DEC_NUM_RP-1:0]  x0_sel,      // read port addresses register 0
   input  logic [`DEC_NUM_RP-1:0]  rd_nz,       // read port returns nonzero data
   input  logic                    int_wb,      // interrupt taken at wb
   input  dec_pkg::trace_pkt_t     trace_pkt    // retirement trace
);

   int fail_cnt = 0;                        // read back by the testbench

   a_x0_zero : assert property (@(posedge clk) (x0_sel & rd_nz) == '0)
      else begin
         $error("register 0 read back a nonzero value");
         fail_cnt++;
      end

   a_trace_rst : assert property (@(posedge clk) rst |=> trace_pkt.valid == '0)
      else begin
         $error("trace valid set in the cycle after reset");
         fail_cnt++;
      end

   // interrupt lands on the top lane one cycle late, instruction lanes stay clear
   a_int_lanes : assert property (@(posedge clk)
                                  !rst |=> trace_pkt.interrupt == {$past(int_wb), 2'b00})
      else begin
         $error("trace interrupt lanes do not follow the wb interrupt");
         fail_cnt++;
      end

endmodule

/* dv/tb_dec.sv */
`timescale 1ns/1ps
`include "dec_cfg.svh"

module tb_dec;

   import dec_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_FIELDS = 19;

   logic        clk, rst;
   gpr_addr_t   i0_waddr_wb, i1_waddr_wb, nbload_waddr;
   logic        i0_wen_wb, i1_wen_wb, nbload_wen;
   gpr_data_t   i0_wdata_wb, i1_wdata_wb, nbload_wdata;
   gpr_addr_t   i0_rs1, i0_rs2, i1_rs1, i1_rs2;
   logic        i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en;
   gpr_data_t   gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d;
   gpr_data_t   dbg_rddata;
   logic        i0_valid_wb, i1_valid_wb, i0_exc_valid_wb, i1_exc_valid_wb, int_valid_wb;
   gpr_data_t   i0_inst_wb, i1_inst_wb, mtval_wb;
   logic [31:1] i0_pc_wb, i1_pc_wb;
   logic [4:0]  exc_cause_wb;
   trace_pkt_t  trace_rv_trace_pkt;

   gpr_data_t   model [`DEC_NUM_GPR];  // reference register file
   trace_pkt_t  exp_trace;             // packet due after the next edge
   logic [31:0] v [NUM_FIELDS];        // fields of the current line
   string       lines [$];
   int          seed = 4843;
   bit          loaded = 1'b0;

   dec i_dec (.*);

   bind dec_gpr_ctl dec_sva gpr_sva (
      .clk       (clk),
      .rst       (rst),
      .x0_sel    ({raddr[3] == '0, raddr[2] == '0, raddr[1] == '0, raddr[0] == '0}),
      .rd_nz     ({|rd[3], |rd[2], |rd[1], |rd[0]}),
      .int_wb    (1'b0),
      .trace_pkt ('0)
   );

   bind dec_trace dec_sva trc_sva (
      .clk       (clk),
      .rst       (rst),
      .x0_sel    ('0),
      .rd_nz     ('0),
      .int_wb    (int_valid_wb),
      .trace_pkt (trace_pkt)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic abort_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(string sig, logic [255:0] exp, logic [255:0] act);
      assert (act === exp) else begin
         $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
         abort_run();
      end
   endtask

   function automatic gpr_data_t model_read(gpr_addr_t addr, logic en);
      return (en && addr != '0) ? model[addr] : '0;   // x0 and idle ports read zero
   endfunction

   // ************************************************************
   // one stimulus line: drive, check, advance reference
   // ************************************************************

   task automatic drive_inputs();
      {i0_wen_wb, i0_waddr_wb, i0_wdata_wb}    = {v[0][0], v[1][4:0], v[2]};
      {i1_wen_wb, i1_waddr_wb, i1_wdata_wb}    = {v[3][0], v[4][4:0], v[5]};
      {nbload_wen, nbload_waddr, nbload_wdata} = {v[6][0], v[7][4:0], v[8]};
      {i1_rs2_en, i1_rs1_en, i0_rs2_en, i0_rs1_en} = v[9][3:0];
      {i0_rs1, i0_rs2} = {v[10][4:0], v[11][4:0]};
      {i1_rs1, i1_rs2} = {v[12][4:0], v[13][4:0]};
      {int_valid_wb, i1_exc_valid_wb, i0_exc_valid_wb, i1_valid_wb, i0_valid_wb} = v[14][4:0];
      i0_inst_wb   = $random(seed);    // retire payload is filler
      i1_inst_wb   = $random(seed);
      i0_pc_wb     = 31'($random(seed));
      i1_pc_wb     = 31'($random(seed));
      exc_cause_wb = 5'($random(seed));
      mtval_wb     = $random(seed);
   endtask

   task automatic check_outputs(int line_no);
      logic [`DEC_NUM_RP-1:0] en;
      gpr_addr_t              addr [`DEC_NUM_RP];
      en   = {i1_rs2_en, i1_rs1_en, i0_rs2_en, i0_rs1_en};
      addr = '{i0_rs1, i0_rs2, i1_rs1, i1_rs2};
      for (int r = 0; r < `DEC_NUM_RP; r++) begin
         assert (model_read(addr[r], en[r]) === v[15+r]) else begin
            $display("stimulus line %0d expects a read value the model does not hold", line_no);
            abort_run();
         end
      end
      check_value("gpr_i0_rs1_d", v[15], gpr_i0_rs1_d);
      check_value("gpr_i0_rs2_d", v[16], gpr_i0_rs2_d);
      check_value("gpr_i1_rs1_d", v[17], gpr_i1_rs1_d);
      check_value("gpr_i1_rs2_d", v[18], gpr_i1_rs2_d);
      check_value("dbg_rddata", i0_wdata_wb, dbg_rddata);
      check_value("trace_rv_trace_pkt", exp_trace, trace_rv_trace_pkt);   // previous line
   endtask

   task automatic advance_model();
      exp_trace.valid     = {int_valid_wb, i1_valid_wb | i1_exc_valid_wb,
                             i0_valid_wb | i0_exc_valid_wb};
      exp_trace.exception = {int_valid_wb, i1_exc_valid_wb, i0_exc_valid_wb};
      exp_trace.interrupt = {int_valid_wb, 2'b00};
      exp_trace.ecause    = exc_cause_wb;
      exp_trace.tval      = mtval_wb;
      exp_trace.insn      = {32'h0, i1_inst_wb, i0_inst_wb};
      exp_trace.address   = {32'h0, i1_pc_wb, 1'b0, i0_pc_wb, 1'b0};
      // later port overwrites earlier, nbload wins
      if (i0_wen_wb && i0_waddr_wb != '0) model[i0_waddr_wb] = i0_wdata_wb;
      if (i1_wen_wb && i1_waddr_wb != '0) model[i1_waddr_wb] = i1_wdata_wb;
      if (nbload_wen && nbload_waddr != '0) model[nbload_waddr] = nbload_wdata;
   endtask

   // ************************************************************
   // main sequence
   // ************************************************************

   initial begin
      int    fd;
      int    cnt;
      int    sva_fails;
      string ln;
      rst = 1'b1;
      for (int i = 0; i < NUM_FIELDS; i++) v[i] = '0;
      drive_inputs();
      {i0_inst_wb, i1_inst_wb, i0_pc_wb, i1_pc_wb, exc_cause_wb, mtval_wb} = '0;
      exp_trace = '0;                                   // reset view of the trace
      foreach (model[i]) model[i] = '0;
      fd = $fopen("dv/dec_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open dv/dec_stimulus.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         ln = "";
         void'($fgets(ln, fd));
         if (ln.len() > 1 && ln[0] != "#") lines.push_back(ln);   // skip comments, blanks
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      foreach (lines[i]) begin
         @(negedge clk);
         cnt = $sscanf(lines[i], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                       v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
         if (cnt != NUM_FIELDS) begin
            $display("stimulus line %0d has %0d fields instead of %0d", i, cnt, NUM_FIELDS);
            abort_run();
         end
         rst = 1'b0;
         drive_inputs();
         #(CLK_PERIOD/4);                               // settled, well before posedge
         check_outputs(i);
         advance_model();
      end
      @(negedge clk);
      sva_fails = i_dec.arf.gpr_sva.fail_cnt + i_dec.trc.trc_sva.fail_cnt;
      if (sva_fails == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         $display("bound assertions failed %0d times", sva_fails);
         abort_run();
      end
   end

   // watchdog sized from the stimulus length
   initial begin
      wait (loaded);
      #((lines.size() + 10) * CLK_PERIOD);
      $display("timeout, stimulus did not complete in time");
      abort_run();
   end

endmodule

/* dv/dec_stimulus.txt */
# hex: i0 wen addr data, i1 wen addr data, nbload wen addr data, rden[3:0], rs addr x4
# then retire {int,i1exc,i0exc,i1v,i0v}, expected read data i0rs1 i0rs2 i1rs1 i1rs2
0 00 00000000 0 00 00000000 0 00 00000000 f 01 02 1f 00 00 00000000 00000000 00000000 00000000
1 05 a5a5a5a5 0 00 00000000 0 00 00000000 f 05 05 05 05 03 00000000 00000000 00000000 00000000
0 00 00000000 1 06 12345678 0 00 00000000 f 05 05 05 05 04 a5a5a5a5 a5a5a5a5 a5a5a5a5 a5a5a5a5
0 00 00000000 0 00 00000000 1 07 deadbeef f 06 06 06 06 08 12345678 12345678 12345678 12345678
1 05 0badf00d 0 00 00000000 0 00 00000000 f 07 07 07 05 10 deadbeef deadbeef deadbeef a5a5a5a5
1 00 ffffffff 0 00 00000000 0 00 00000000 f 05 00 05 00 1f 0badf00d 00000000 0badf00d 00000000
0 00 00000000 1 00 eeeeeeee 1 00 dddddddd f 00 00 00 00 00 00000000 00000000 00000000 00000000
0 00 00000000 0 00 00000000 0 00 00000000 0 05 06 07 05 01 00000000 00000000 00000000 00000000
0 00 00000000 0 00 00000000 0 00 00000000 5 05 06 07 05 02 0badf00d 00000000 deadbeef 00000000
1 0a 11111111 1 0a 22222222 1 0a 33333333 f 0a 0a 0a 0a 00 00000000 00000000 00000000 00000000
1 0b 44444444 1 0b 55555555 0 00 00000000 f 0a 0a 0a 0a 00 33333333 33333333 33333333 33333333
1 0c 66666666 0 00 00000000 1 0c 77777777 f 0b 0b 0b 0b 00 55555555 55555555 55555555 55555555
0 00 00000000 1 0d 88888888 1 0d 99999999 f 0c 0c 0c 0c 00 77777777 77777777 77777777 77777777
0 0e 12121212 0 00 00000000 0 00 00000000 f 0d 0d 0e 0e 00 99999999 99999999 00000000 00000000
1 1f cafe0001 1 01 00000101 1 1e fee1dead f 0e 0e 0e 0e 05 00000000 00000000 00000000 00000000
0 00 00000000 0 00 00000000 0 00 00000000 f 1f 01 1e 0d 0a cafe0001 00000101 fee1dead 99999999
0 00 00000000 0 00 00000000 0 00 00000000 0 00 00 00 00 00 00000000 00000000 00000000 00000000

/* sources.f */
+incdir+common
common/dec_pkg.sv
common/gpr_wr_if.sv
arf/dec_gpr_wsel.sv
arf/dec_gpr_entry.sv
arf/dec_gpr_rmux.sv
arf/dec_gpr_ctl.sv
source/dec_trace.sv
source/dec.sv
dv/dec_sva.sv
dv/tb_dec.sv
